//--- vlog.f
rtl/mips_muldiv_pkg.sv
rtl/multiplier.sv
rtl/divider.sv
rtl/muldiv_unit.sv
rtl/hilo_file.sv
rtl/muldiv_top.sv
tb/muldiv_ref.sv
tb/muldiv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the muldiv testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module muldiv_tb -f vlog.f -o Vmuldiv_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmuldiv_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb/muldiv_tb.sv
`timescale 1ns/100ps

module muldiv_tb;
    import mips_muldiv_pkg::*;
    import muldiv_ref::*;

    logic        clk;
    logic        reset;
    decoded_op_t op;
    word_t       a;
    word_t       b;
    logic        mthi;
    logic        mtlo;
    word_t       wdata;
    logic        busy;
    logic        done;
    word_t       hi;
    word_t       lo;

    // expected results in issue order, one per done pulse
    hilo_t exp_q[$];
    hilo_t got_hilo;
    logic  done_q;
    int    tests_passed;
    int    tests_failed;
    int    errs_at_start;
    word_t corners[4];

    muldiv_top muldiv_top_inst (
        .clk, .reset, .op, .a, .b, .mthi, .mtlo, .wdata,
        .busy, .done, .hi, .lo
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hi/lo load on the edge that ends the done cycle
    // compared at the falling edge after it
    always @(negedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else begin
            if (done_q) begin
                got_hilo.product = {hi, lo};
                if (exp_q.size() == 0) begin
                    $display("done pulsed at %0t with no operation outstanding", $time);
                    error_count++;
                end else begin
                    check_hilo("hi/lo after done", got_hilo, exp_q.pop_front());
                end
            end
            done_q <= done;
        end
    end

    // one-cycle strobe, returns on the accept edge
    task automatic issue(input decoded_op_t o, input word_t x, input word_t y);
        @(posedge clk);
        op <= o;
        a  <= x;
        b  <= y;
        @(posedge clk);
        op <= OP_NONE;
    endtask

    // edges from the current one until done is seen high
    task automatic wait_done(output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        if (!seen) begin
            $display("timeout: no done pulse within %0d cycles at %0t", DONE_TIMEOUT, $time);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    // latency checked here, hi/lo by the compare process
    task automatic run_op(input decoded_op_t o, input word_t x, input word_t y);
        int cycles;
        exp_q.push_back(ref_hilo(o, x, y));
        issue(o, x, y);
        wait_done(cycles);
        check_word($sformatf("%s latency", o.name()), word_t'(cycles),
                   (o == DIV || o == DIVU) ? word_t'(DIV_LATENCY) : word_t'(MULT_LATENCY));
        repeat (2) @(posedge clk);
    endtask

    // direct move with no result pending
    // other is what the untouched register should still hold
    task automatic move_reg(input bit to_hi, input word_t w, input word_t other);
        @(posedge clk);
        mthi  <= to_hi;
        mtlo  <= !to_hi;
        wdata <= w;
        @(posedge clk);
        mthi <= 1'b0;
        mtlo <= 1'b0;
        @(negedge clk);
        check_word("moved register", to_hi ? hi : lo, w);
        check_word("untouched register", to_hi ? lo : hi, other);
    endtask

    // move lands in the done cycle, the other half still takes the result
    task automatic move_at_done(input decoded_op_t o, input word_t x, input word_t y,
                                input bit to_hi, input word_t w);
        hilo_t r;
        r = ref_hilo(o, x, y);
        if (to_hi) begin
            r.product[63:32] = w;
        end else begin
            r.product[31:0] = w;
        end
        exp_q.push_back(r);
        issue(o, x, y);
        repeat ((o == DIV || o == DIVU) ? DIV_LATENCY : MULT_LATENCY) @(posedge clk);
        mthi  <= to_hi;
        mtlo  <= !to_hi;
        wdata <= w;
        @(negedge clk);
        check_bit("done alongside the move", done, 1'b1);
        @(posedge clk);
        mthi <= 1'b0;
        mtlo <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (error_count == errs_at_start) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errs_at_start);
            tests_failed++;
        end
        errs_at_start = error_count;
    endtask

    // sometimes shifted down so divides see small divisors
    function automatic word_t rand_word();
        word_t w;
        w = $urandom;
        if ($urandom % 2) begin
            w = w >> ($urandom % 32);
        end
        return w;
    endfunction

    initial begin
        int    cycles;
        hilo_t last_exp;
        void'($urandom(32'h44e2_5649));
        reset = 1'b1;
        op    = OP_NONE;
        a     = '0;
        b     = '0;
        mthi  = 1'b0;
        mtlo  = 1'b0;
        wdata = '0;
        tests_passed  = 0;
        tests_failed  = 0;
        errs_at_start = 0;
        corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000};
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_bit("busy after reset", busy, 1'b0);
        check_bit("done after reset", done, 1'b0);
        check_word("hi after reset", hi, '0);
        check_word("lo after reset", lo, '0);
        end_test("reset state");

        foreach (corners[i]) begin
            foreach (corners[j]) begin
                run_op(MULT, corners[i], corners[j]);
                run_op(MULTU, corners[i], corners[j]);
            end
        end
        repeat (200) run_op(($urandom % 2) ? MULT : MULTU, rand_word(), rand_word());
        end_test("multiply");

        // corner pairs cover divide by zero and the signed overflow
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                run_op(DIV, corners[i], corners[j]);
                run_op(DIVU, corners[i], corners[j]);
            end
        end
        run_op(DIV, 32'h8765_4321, '0);
        repeat (200) run_op(($urandom % 2) ? DIV : DIVU, rand_word(), rand_word());
        end_test("divide");

        // second strobe lands two cycles into a divide
        exp_q.push_back(ref_hilo(DIV, 32'hffff_ff9c, 32'h7));
        issue(DIV, 32'hffff_ff9c, 32'h7);
        repeat (2) @(posedge clk);
        op <= MULTU;
        a  <= 32'h1234;
        b  <= 32'h5678;
        @(negedge clk);
        check_bit("busy during ignored strobe", busy, 1'b1);
        @(posedge clk);
        op <= OP_NONE;
        wait_done(cycles);
        check_word("divide latency past ignored strobe", word_t'(cycles + 3),
                   word_t'(DIV_LATENCY));
        repeat (2) @(posedge clk);
        // next strobe held during the done cycle
        exp_q.push_back(ref_hilo(MULTU, 32'hdead_beef, 32'h1000_0001));
        issue(MULTU, 32'hdead_beef, 32'h1000_0001);
        repeat (MULT_LATENCY) @(posedge clk);
        last_exp = ref_hilo(MULT, 32'h8000_0001, 32'hffff_fffe);
        exp_q.push_back(last_exp);
        op <= MULT;
        a  <= 32'h8000_0001;
        b  <= 32'hffff_fffe;
        @(negedge clk);
        check_bit("done with next strobe present", done, 1'b1);
        @(posedge clk);
        op <= OP_NONE;
        wait_done(cycles);
        check_word("back to back latency", word_t'(cycles), word_t'(MULT_LATENCY));
        repeat (2) @(posedge clk);
        end_test("strobe while busy");

        // lo still holds the last product until its own move
        move_reg(1'b1, 32'h1357_9bdf, last_exp.product[31:0]);
        move_reg(1'b0, 32'h2468_ace0, 32'h1357_9bdf);
        move_at_done(MULT, 32'h0001_2345, 32'hffff_8000, 1'b1, 32'h0bad_cafe);
        move_at_done(DIVU, 32'hcafe_f00d, 32'h0000_0123, 1'b0, 32'h600d_f00d);
        end_test("direct moves");

        if (exp_q.size() != 0) begin
            $display("%0d operations never signalled done", exp_q.size());
            error_count++;
        end
        $display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/muldiv_ref.sv
package muldiv_ref;
    import mips_muldiv_pkg::*;

    // cycles any wait for done may take
    localparam int DONE_TIMEOUT = 100;

    // running error total across all checks
    int error_count = 0;

    // expected hi/lo for one operation, built from the MIPS rules
    function automatic hilo_t ref_hilo(decoded_op_t op, word_t a, word_t b);
        hilo_t       r;
        int          sa;
        int          sb;
        logic [63:0] wide;
        r  = '0;
        sa = a;
        sb = b;
        case (op)
            MULT: begin
                wide      = longint'(sa) * longint'(sb);
                r.product = wide;
            end
            MULTU: begin
                wide      = {32'b0, a} * {32'b0, b};
                r.product = wide;
            end
            DIV, DIVU: begin
                if (b == '0) begin
                    // all-ones quotient and the dividend as remainder
                    r.div.quot = '1;
                    r.div.rem  = a;
                end else if (op == DIVU) begin
                    r.div.quot = a / b;
                    r.div.rem  = a % b;
                end else if (a == 32'h8000_0000 && b == '1) begin
                    // most negative over minus one wraps
                    r.div.quot = 32'h8000_0000;
                    r.div.rem  = '0;
                end else begin
                    // truncating divide, remainder keeps the dividend sign
                    r.div.quot = sa / sb;
                    r.div.rem  = sa % sb;
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic check_word(input string msg, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %h expected %h", $time, msg, got, exp);
            error_count++;
        end
    endtask

    // single control levels such as busy and done
    task automatic check_bit(input string msg, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %b expected %b", $time, msg, got, exp);
            error_count++;
        end
    endtask

    task automatic check_hilo(input string msg, input hilo_t got, input hilo_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got hi %h lo %h expected hi %h lo %h", $time, msg,
                     got.product[63:32], got.product[31:0],
                     exp.product[63:32], exp.product[31:0]);
            error_count++;
        end
    endtask

endpackage

//--- rtl/muldiv_top.sv
`timescale 1ns/100ps

module muldiv_top (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_muldiv_pkg::decoded_op_t op,
    input  mips_muldiv_pkg::word_t      a,
    input  mips_muldiv_pkg::word_t      b,
    input  logic                        mthi,
    input  logic                        mtlo,
    input  mips_muldiv_pkg::word_t      wdata,
    output logic                        busy,
    output logic                        done,
    output mips_muldiv_pkg::word_t      hi,
    output mips_muldiv_pkg::word_t      lo
);
    import mips_muldiv_pkg::*;

    // completed result on its way to hi/lo
    hilo_t result;

    muldiv_unit u_unit (
        .clk,
        .reset,
        .op,
        .a,
        .b,
        .busy,
        .done,
        .result
    );

    hilo_file u_hilo (
        .clk,
        .reset,
        .done,
        .result,
        .mthi,
        .mtlo,
        .wdata,
        .hi,
        .lo
    );

endmodule

//--- rtl/hilo_file.sv
`timescale 1ns/100ps

module hilo_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   done,
    input  mips_muldiv_pkg::hilo_t result,
    input  logic                   mthi,
    input  logic                   mtlo,
    input  mips_muldiv_pkg::word_t wdata,
    output mips_muldiv_pkg::word_t hi,
    output mips_muldiv_pkg::word_t lo
);

    // upper half is hi for both product and rem/quot
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
        end else if (mthi) begin
            // move is younger in program order than the result
            hi <= wdata;
        end else if (done) begin
            hi <= result.product[63:32];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lo <= '0;
        end else if (mtlo) begin
            lo <= wdata;
        end else if (done) begin
            lo <= result.product[31:0];
        end
    end

endmodule

//--- rtl/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_muldiv_pkg::decoded_op_t op,
    input  mips_muldiv_pkg::word_t      a,
    input  mips_muldiv_pkg::word_t      b,
    output logic                        busy,
    output logic                        done,
    output mips_muldiv_pkg::hilo_t      result
);
    import mips_muldiv_pkg::*;

    // idle when low, running when high
    logic               running;
    // which unit was launched
    logic               use_div;
    logic [COUNT_W-1:0] count;

    // decode of the incoming strobe
    logic is_mul_op;
    logic is_div_op;
    logic is_signed;
    logic accept;
    logic finish;

    // unit handshakes
    logic    mul_start;
    logic    div_start;
    logic    mul_valid;
    logic    div_valid;
    logic    unit_valid;
    dword_t  mul_product;
    divres_t div_result;

    assign is_mul_op = (op == MULT) || (op == MULTU);
    assign is_div_op = (op == DIV) || (op == DIVU);
    assign is_signed = (op == MULT) || (op == DIV);

    // strobes seen while running are dropped
    assign accept    = !running && (is_mul_op || is_div_op);
    assign mul_start = accept && is_mul_op;
    assign div_start = accept && is_div_op;

    assign busy = running;

    // counter expired and the launched unit agrees
    assign unit_valid = use_div ? div_valid : mul_valid;
    assign finish     = running && (count == '0) && unit_valid;

    multiplier u_mul (
        .clk,
        .reset,
        .start     (mul_start),
        .is_signed (is_signed),
        .a,
        .b,
        .product   (mul_product),
        .valid     (mul_valid)
    );

    divider u_div (
        .clk,
        .reset,
        .start     (div_start),
        .is_signed (is_signed),
        .a,
        .b,
        .result    (div_result),
        .valid     (div_valid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            use_div <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                running <= 1'b1;
                use_div <= is_div_op;
                // minus one since the accept edge counts
                count   <= is_div_op ? COUNT_W'(DIV_LATENCY - 1)
                                     : COUNT_W'(MULT_LATENCY - 1);
            end else if (running) begin
                if (count != '0) begin
                    count <= count - 1'b1;
                end else if (unit_valid) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // steer the launched unit into the matching union view
    always_ff @(posedge clk) begin
        if (finish) begin
            if (use_div) begin
                result.div <= div_result;
            end else begin
                result.product <= mul_product;
            end
        end
    end

endmodule

//--- rtl/divider.sv
`timescale 1ns/100ps

module divider (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     is_signed,
    input  mips_muldiv_pkg::word_t   a,
    input  mips_muldiv_pkg::word_t   b,
    output mips_muldiv_pkg::divres_t result,
    output logic                     valid
);
    import mips_muldiv_pkg::*;

    // control
    logic       running;
    logic       fixing;
    logic [4:0] step;

    // operand signs and magnitudes
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;

    // datapath
    word_t rem_r;
    word_t quot_r;
    word_t divisor_r;
    logic  neg_q;
    logic  neg_r;
    logic  div_zero;

    // one restoring step
    logic [32:0] shifted;
    logic [33:0] diff;

    assign a_neg = is_signed & a[31];
    assign b_neg = is_signed & b[31];
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    // bring the next dividend bit into the partial remainder
    assign shifted = {rem_r, quot_r[31]};
    // trial subtract, top bit set means it did not fit
    assign diff    = {1'b0, shifted} - {2'b00, divisor_r};

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            fixing  <= 1'b0;
            step    <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (start) begin
                running <= 1'b1;
                fixing  <= 1'b0;
                step    <= '0;
            end else if (running) begin
                step <= step + 5'd1;
                // last of 32 steps, sign fix next
                if (step == 5'd31) begin
                    running <= 1'b0;
                    fixing  <= 1'b1;
                end
            end else if (fixing) begin
                fixing <= 1'b0;
                valid  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_r     <= '0;
            quot_r    <= a_mag;
            divisor_r <= b_mag;
            // quotient sign from both operands
            neg_q     <= a_neg ^ b_neg;
            // remainder follows the dividend
            neg_r     <= a_neg;
            div_zero  <= (b == '0);
        end else if (running) begin
            if (!diff[33]) begin
                rem_r  <= diff[31:0];
                quot_r <= {quot_r[30:0], 1'b1};
            end else begin
                rem_r  <= shifted[31:0];
                quot_r <= {quot_r[30:0], 1'b0};
            end
        end

        if (fixing) begin
            // x/0 gives all ones, remainder ends up equal to the dividend
            if (div_zero) begin
                result.quot <= '1;
            end else begin
                result.quot <= neg_q ? -quot_r : quot_r;
            end
            // 0x8000_0000 / -1 wraps to 0x8000_0000 with rem 0
            result.rem <= neg_r ? -rem_r : rem_r;
        end
    end

endmodule

//--- rtl/multiplier.sv
`timescale 1ns/100ps

module multiplier (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    is_signed,
    input  mips_muldiv_pkg::word_t  a,
    input  mips_muldiv_pkg::word_t  b,
    output mips_muldiv_pkg::dword_t product,
    output logic                    valid
);
    import mips_muldiv_pkg::*;

    // stage 1: operands widened to 33 bits
    logic [32:0] a_s1;
    logic [32:0] b_s1;

    // 16-bit halves, signed views for the cross products
    logic signed [17:0] a_lo_s;
    logic signed [17:0] b_lo_s;
    logic signed [16:0] a_hi_s;
    logic signed [16:0] b_hi_s;

    // stage 2: partial products
    logic [31:0]        pp_ll;
    logic signed [34:0] pp_lh;
    logic signed [34:0] pp_hl;
    logic signed [33:0] pp_hh;

    // stage 3: cross terms folded into the low part
    logic signed [35:0] mid;
    logic signed [63:0] mid_ext;
    dword_t             low_s3;
    word_t              hh_s3;

    // valid bit per stage
    logic v1;
    logic v2;
    logic v3;

    // low halves are always unsigned, high halves carry the sign
    assign a_lo_s = $signed({2'b00, a_s1[15:0]});
    assign b_lo_s = $signed({2'b00, b_s1[15:0]});
    assign a_hi_s = $signed(a_s1[32:16]);
    assign b_hi_s = $signed(b_s1[32:16]);

    assign mid     = pp_lh + pp_hl;
    assign mid_ext = mid;

    always_ff @(posedge clk) begin
        // sign or zero extend into the extra top bit
        a_s1 <= {is_signed & a[31], a};
        b_s1 <= {is_signed & b[31], b};

        pp_ll <= a_s1[15:0] * b_s1[15:0];
        pp_lh <= a_lo_s * b_hi_s;
        pp_hl <= a_hi_s * b_lo_s;
        pp_hh <= a_hi_s * b_hi_s;

        // low part plus cross terms at weight 2^16
        low_s3 <= (mid_ext <<< 16) + {32'b0, pp_ll};
        // only the low word of hh survives the shift by 32
        hh_s3  <= pp_hh[31:0];

        product <= low_s3 + {hh_s3, 32'b0};
    end

    // valid travels with the data
    always_ff @(posedge clk) begin
        if (reset) begin
            v1    <= 1'b0;
            v2    <= 1'b0;
            v3    <= 1'b0;
            valid <= 1'b0;
        end else begin
            v1    <= start;
            v2    <= v1;
            v3    <= v2;
            valid <= v3;
        end
    end

endmodule

//--- rtl/mips_muldiv_pkg.sv
package mips_muldiv_pkg;

    // operand and architectural register width
    typedef logic [31:0] word_t;

    // raw 64-bit result before it is split into hi/lo
    typedef logic [63:0] dword_t;

    // decoded hi/lo operation from the core
    // one-cycle strobe, OP_NONE when nothing is issued
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        MULT    = 3'd1,
        MULTU   = 3'd2,
        DIV     = 3'd3,
        DIVU    = 3'd4
    } decoded_op_t;

    // division result
    // remainder in the upper word so it lands in hi
    // quotient in the lower word for lo
    typedef struct packed {
        word_t rem;
        word_t quot;
    } divres_t;

    // one result word with two readings
    // product view for multiplies
    // remainder/quotient view for divides
    // upper 32 bits feed hi in both views
    typedef union packed {
        dword_t  product;
        divres_t div;
    } hilo_t;

    // start strobe to done for a multiply
    localparam int MULT_LATENCY = 4;

    // start strobe to done for a divide
    // load cycle, 32 shift-subtract steps, sign fix
    localparam int DIV_LATENCY = 34;

    // latency counter width, must hold DIV_LATENCY - 1
    localparam int COUNT_W = 6;

endpackage
